//--- aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module aluUnit (
	input  logic                 Clock,
	input  logic                 rstN,
	input  logic                 yIn,
	input  logic                 zIn,
	input  logic                 hiIn,
	input  logic                 loIn,
	input  logic                 incPc,
	input  datapathPkg::aluOp_t  opcode,
	input  datapathPkg::word_t   bus,
	output datapathPkg::word_t   yValue,
	output datapathPkg::word_t   zHigh,
	output datapathPkg::word_t   zLow,
	output datapathPkg::word_t   hiValue,
	output datapathPkg::word_t   loValue
);

	localparam int shiftWidth = $clog2(`WORD_WIDTH);

	datapathPkg::word_t           yReg;
	datapathPkg::word_t           hiReg;
	datapathPkg::word_t           loReg;
	datapathPkg::dword_t          zReg;
	datapathPkg::dword_t          zNext;
	datapathPkg::word_t           lowResult;
	logic signed [2*`WORD_WIDTH-1:0] product;
	logic [shiftWidth-1:0]        shiftAmount;

	assign shiftAmount = bus[shiftWidth-1:0];
	assign product = $signed(yReg) * $signed(bus);

	always_comb begin
		case (opcode)
			datapathPkg::opAdd: lowResult = yReg + bus;
			datapathPkg::opSub: lowResult = yReg - bus;
			datapathPkg::opAnd: lowResult = yReg & bus;
			datapathPkg::opOr:  lowResult = yReg | bus;
			datapathPkg::opShr: lowResult = yReg >> shiftAmount;
			datapathPkg::opShl: lowResult = yReg << shiftAmount;
			datapathPkg::opNeg: lowResult = -bus;
			datapathPkg::opNot: lowResult = ~bus;
			default:            lowResult = yReg;
		endcase
	end

	// PC increment overrides the opcode.
	always_comb begin
		if (incPc) begin
			zNext = {{`WORD_WIDTH{1'b0}}, datapathPkg::word_t'(bus + 1'b1)};
		end else if (opcode == datapathPkg::opMul) begin
			zNext = datapathPkg::dword_t'(product);
		end else begin
			zNext = {{`WORD_WIDTH{1'b0}}, lowResult};
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			yReg <= '0;
			hiReg <= '0;
			loReg <= '0;
			zReg <= '0;
		end else begin
			if (yIn) begin
				yReg <= bus;
			end
			if (hiIn) begin
				hiReg <= bus;
			end
			if (loIn) begin
				loReg <= bus;
			end
			if (zIn) begin
				zReg <= zNext;
			end
		end
	end

	assign yValue = yReg;
	assign hiValue = hiReg;
	assign loValue = loReg;
	assign zHigh = zReg[2*`WORD_WIDTH-1:`WORD_WIDTH];
	assign zLow = zReg[`WORD_WIDTH-1:0];

endmodule

`default_nettype wire

//--- busDriver.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module busDriver (
	input  logic                Clock,
	input  logic                rstN,
	input  logic                rOut,
	input  logic                baOut,
	input  logic                pcOut,
	input  logic                yOut,
	input  logic                hiOut,
	input  logic                loOut,
	input  logic                zHighOut,
	input  logic                zLowOut,
	input  logic                mdrOut,
	input  logic                inPortOut,
	input  logic                cOut,
	input  datapathPkg::word_t  regValue,
	input  datapathPkg::word_t  pcValue,
	input  datapathPkg::word_t  irValue,
	input  datapathPkg::word_t  yValue,
	input  datapathPkg::word_t  hiValue,
	input  datapathPkg::word_t  loValue,
	input  datapathPkg::word_t  zHigh,
	input  datapathPkg::word_t  zLow,
	input  datapathPkg::word_t  mdrValue,
	input  datapathPkg::word_t  inPortValue,
	output datapathPkg::word_t  bus
);

	localparam int constWidth = 19;

	datapathPkg::busSrc_t busSrc;
	datapathPkg::word_t   constValue;

	// Sign-extended immediate from the low IR bits.
	assign constValue = {{(`WORD_WIDTH-constWidth){irValue[constWidth-1]}},
		irValue[constWidth-1:0]};

	always_comb begin
		busSrc = datapathPkg::srcNone;
		if (rOut || baOut) begin
			busSrc = datapathPkg::srcReg;
		end else if (pcOut) begin
			busSrc = datapathPkg::srcPc;
		end else if (yOut) begin
			busSrc = datapathPkg::srcY;
		end else if (hiOut) begin
			busSrc = datapathPkg::srcHi;
		end else if (loOut) begin
			busSrc = datapathPkg::srcLo;
		end else if (zHighOut) begin
			busSrc = datapathPkg::srcZHigh;
		end else if (zLowOut) begin
			busSrc = datapathPkg::srcZLow;
		end else if (mdrOut) begin
			busSrc = datapathPkg::srcMdr;
		end else if (inPortOut) begin
			busSrc = datapathPkg::srcInPort;
		end else if (cOut) begin
			busSrc = datapathPkg::srcConst;
		end
	end

	always_comb begin
		case (busSrc)
			datapathPkg::srcReg:    bus = regValue;
			datapathPkg::srcPc:     bus = pcValue;
			datapathPkg::srcY:      bus = yValue;
			datapathPkg::srcHi:     bus = hiValue;
			datapathPkg::srcLo:     bus = loValue;
			datapathPkg::srcZHigh:  bus = zHigh;
			datapathPkg::srcZLow:   bus = zLow;
			datapathPkg::srcMdr:    bus = mdrValue;
			datapathPkg::srcInPort: bus = inPortValue;
			datapathPkg::srcConst:  bus = constValue;
			default:                bus = '0;
		endcase
	end

	// A second driver would be silently lost to the priority above.
	singleDriver: assert property (@(posedge Clock) disable iff (!rstN)
		$onehot0({rOut, baOut, pcOut, yOut, hiOut, loOut, zHighOut, zLowOut,
			mdrOut, inPortOut, cOut}));

endmodule

`default_nettype wire

//--- datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module datapath (
	input  logic                 Clock,
	input  logic                 rstN,
	input  logic                 read,
	input  logic                 write,
	input  logic                 incPc,
	input  datapathPkg::aluOp_t  opcode,
	input  logic                 gra,
	input  logic                 grb,
	input  logic                 grc,
	input  logic                 rIn,
	input  logic                 rOut,
	input  logic                 baOut,
	input  logic                 hiIn,
	input  logic                 loIn,
	input  logic                 yIn,
	input  logic                 zIn,
	input  logic                 pcIn,
	input  logic                 irIn,
	input  logic                 marIn,
	input  logic                 mdrIn,
	input  logic                 inPortIn,
	input  logic                 outPortIn,
	input  logic                 hiOut,
	input  logic                 loOut,
	input  logic                 yOut,
	input  logic                 zHighOut,
	input  logic                 zLowOut,
	input  logic                 pcOut,
	input  logic                 mdrOut,
	input  logic                 inPortOut,
	input  logic                 cOut,
	input  datapathPkg::word_t   inPortData,
	input  logic                 creditReturn,
	output datapathPkg::word_t   outData,
	output logic                 outValid,
	output logic                 outFull
);

	datapathPkg::word_t bus;
	datapathPkg::word_t regValue;
	datapathPkg::word_t pcValue;
	datapathPkg::word_t irValue;
	datapathPkg::word_t yValue;
	datapathPkg::word_t hiValue;
	datapathPkg::word_t loValue;
	datapathPkg::word_t zHigh;
	datapathPkg::word_t zLow;
	datapathPkg::word_t mdrValue;
	datapathPkg::word_t inPortValue;

	busDriver busDriverInst (
		.Clock, .rstN, .rOut, .baOut, .pcOut, .yOut, .hiOut, .loOut,
		.zHighOut, .zLowOut, .mdrOut, .inPortOut, .cOut,
		.regValue, .pcValue, .irValue, .yValue, .hiValue, .loValue,
		.zHigh, .zLow, .mdrValue, .inPortValue, .bus
	);

	registerFile registerFileInst (
		.Clock, .rstN, .gra, .grb, .grc, .rIn, .rOut, .baOut, .pcIn, .irIn,
		.bus, .regValue, .pcValue, .irValue
	);

	aluUnit aluUnitInst (
		.Clock, .rstN, .yIn, .zIn, .hiIn, .loIn, .incPc, .opcode, .bus,
		.yValue, .zHigh, .zLow, .hiValue, .loValue
	);

	memoryInterface memoryInterfaceInst (
		.Clock, .rstN, .marIn, .mdrIn, .read, .write, .bus, .mdrValue
	);

	outPortLink outPortLinkInst (
		.Clock, .rstN, .outPortIn, .inPortIn, .creditReturn, .bus, .inPortData,
		.inPortValue, .outData, .outValid, .outFull
	);

endmodule

`default_nettype wire

//--- datapathChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module datapathChecker (
	input  logic                Clock,
	input  logic                rstN,
	input  logic                outPortIn,
	input  logic                creditReturn,
	input  logic                outValid,
	input  logic                outFull,
	input  datapathPkg::word_t  outData,
	input  logic                expValid,
	input  datapathPkg::word_t  expWord,
	input  logic                endOfTest,
	output int                  errorCount,
	output int                  checkCount,
	output int                  pendingCount,
	output logic                endReported
);

	datapathPkg::word_t expected [$];
	datapathPkg::word_t headWord;
	int                 heldWords;
	int                 freeCredits;
	logic               validModel;

	initial begin
		errorCount = 0;
		checkCount = 0;
		pendingCount = 0;
		endReported = 1'b0;
		heldWords = 0;
		freeCredits = `SINK_CREDITS;
	end

	// Reference model of the queue occupancy and the sink credits.
	always @(posedge Clock) begin
		if (!rstN) begin
			heldWords = 0;
			freeCredits = `SINK_CREDITS;
			expected.delete();
		end else begin
			validModel = (heldWords != 0) && (freeCredits != 0);
			checkCount++;
			if (outFull != (heldWords == `OUT_QUEUE_DEPTH)) begin
				errorCount++;
				$display("** Error at %0t: outFull is %0b with %0d words queued",
					$time, outFull, heldWords);
			end
			if (outValid && !validModel) begin
				errorCount++;
				$display("Unexpected outValid at %0t: no word may leave the queue now", $time);
			end else if (!outValid && validModel) begin
				errorCount++;
				$display("Missing outValid at %0t: a queued word with credit was held back",
					$time);
			end
			if (outValid) begin
				if (expected.size() == 0) begin
					errorCount++;
					$display("Unexpected word %h at %0t: no output word was expected",
						outData, $time);
				end else begin
					headWord = expected.pop_front();
					checkCount++;
					if (outData !== headWord) begin
						errorCount++;
						$display("** Error at %0t: out word %h, expected %h",
							$time, outData, headWord);
					end
				end
			end
			heldWords = heldWords + int'(outPortIn) - int'(validModel);
			freeCredits = freeCredits - int'(validModel) + int'(creditReturn);
			if (expValid) begin
				expected.push_back(expWord);
			end
			if (endOfTest && !endReported) begin
				if (expected.size() != 0) begin
					errorCount++;
					$display("Missing output: %0d expected words never appeared",
						expected.size());
				end
				endReported = 1'b1;
			end
			pendingCount = expected.size();
		end
	end

endmodule

`default_nettype wire

//--- datapathPkg.sv
`default_nettype none

`include "datapath_consts.svh"

package datapathPkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;

	// Z register holds a full product.
	typedef logic [2*`WORD_WIDTH-1:0] dword_t;

	// Codes not listed here pass Y through.
	typedef enum logic [4:0] {
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd5,
		opOr  = 5'd6,
		opShr = 5'd7,
		opShl = 5'd9,
		opMul = 5'd14,
		opNeg = 5'd16,
		opNot = 5'd17
	} aluOp_t;

	typedef enum logic [3:0] {
		srcNone,
		srcReg,
		srcPc,
		srcY,
		srcHi,
		srcLo,
		srcZHigh,
		srcZLow,
		srcMdr,
		srcInPort,
		srcConst
	} busSrc_t;

endpackage

`default_nettype wire

//--- datapath_consts.svh
`ifndef DATAPATH_CONSTS_SVH
`define DATAPATH_CONSTS_SVH

// Width of one datapath word.
`define WORD_WIDTH 32

// General purpose registers R0 to R15.
`define REG_COUNT 16

// Word memory size; the address comes from the low MAR bits.
`define MEM_DEPTH 512

// Words the output port can hold while the sink is out of credit.
`define OUT_QUEUE_DEPTH 4

// Words the sink accepts before it must return credit.
`define SINK_CREDITS 2

`endif

//--- datapath_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module datapath_tb;

	// Control word layout, bit 0 upward; the top bit withholds sink credit.
	localparam logic [28:0] mRead      = 29'd1 << 0;
	localparam logic [28:0] mWrite     = 29'd1 << 1;
	localparam logic [28:0] mIncPc     = 29'd1 << 2;
	localparam logic [28:0] mGra       = 29'd1 << 3;
	localparam logic [28:0] mGrb       = 29'd1 << 4;
	localparam logic [28:0] mGrc       = 29'd1 << 5;
	localparam logic [28:0] mRIn       = 29'd1 << 6;
	localparam logic [28:0] mROut      = 29'd1 << 7;
	localparam logic [28:0] mBaOut     = 29'd1 << 8;
	localparam logic [28:0] mHiIn      = 29'd1 << 9;
	localparam logic [28:0] mLoIn      = 29'd1 << 10;
	localparam logic [28:0] mYIn       = 29'd1 << 11;
	localparam logic [28:0] mZIn       = 29'd1 << 12;
	localparam logic [28:0] mPcIn      = 29'd1 << 13;
	localparam logic [28:0] mIrIn      = 29'd1 << 14;
	localparam logic [28:0] mMarIn     = 29'd1 << 15;
	localparam logic [28:0] mMdrIn     = 29'd1 << 16;
	localparam logic [28:0] mInPortIn  = 29'd1 << 17;
	localparam logic [28:0] mOutPortIn = 29'd1 << 18;
	localparam logic [28:0] mHiOut     = 29'd1 << 19;
	localparam logic [28:0] mLoOut     = 29'd1 << 20;
	localparam logic [28:0] mYOut      = 29'd1 << 21;
	localparam logic [28:0] mZHighOut  = 29'd1 << 22;
	localparam logic [28:0] mZLowOut   = 29'd1 << 23;
	localparam logic [28:0] mPcOut     = 29'd1 << 24;
	localparam logic [28:0] mMdrOut    = 29'd1 << 25;
	localparam logic [28:0] mInPortOut = 29'd1 << 26;
	localparam logic [28:0] mCOut      = 29'd1 << 27;
	localparam logic [28:0] mHold      = 29'd1 << 28;

	localparam datapathPkg::word_t aluA = 32'h0000_F0F3;
	localparam datapathPkg::word_t aluB = 32'h0000_0105;
	localparam datapathPkg::word_t mulA = 32'h0001_2345;
	localparam datapathPkg::word_t mulB = 32'h0010_0003;

	logic Clock, rstN, read, write, incPc, gra, grb, grc, rIn, rOut, baOut;
	logic hiIn, loIn, yIn, zIn, pcIn, irIn, marIn, mdrIn, inPortIn, outPortIn;
	logic hiOut, loOut, yOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut;
	logic creditReturn, outValid, outFull, expValid, endOfTest, endReported;
	datapathPkg::aluOp_t opcode;
	datapathPkg::word_t  inPortData, outData, expWord;
	int                  errorCount, checkCount, pendingCount;

	logic [28:0]         ctlQ [$];
	datapathPkg::aluOp_t opQ [$];
	datapathPkg::word_t  dataQ [$];
	bit                  expQ [$];
	datapathPkg::word_t  expWordQ [$];
	logic [31:0]         lcgState = 32'h6bd45528;
	int                  pendingCredits = 0;
	int                  cycleCount = 0;
	int                  timeoutLimit = 0;

	datapath DUT (.*);

	datapathChecker outputChecker (
		.Clock, .rstN, .outPortIn, .creditReturn, .outValid, .outFull, .outData,
		.expValid, .expWord, .endOfTest, .errorCount, .checkCount, .pendingCount,
		.endReported
	);

	always #50 Clock = ~Clock;

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// IR with ra at 26:23, rb at 22:19 and rc at 18:15.
	function automatic datapathPkg::word_t irFields(input logic [3:0] ra, input logic [3:0] rb,
		input logic [3:0] rc);
		return {5'd0, ra, rb, rc, 15'd0};
	endfunction

	function automatic datapathPkg::word_t signExtend19(input datapathPkg::word_t w);
		return {{13{w[18]}}, w[18:0]};
	endfunction

	task automatic addRow(input logic [28:0] ctl, input datapathPkg::aluOp_t op,
		input datapathPkg::word_t data, input bit hasExp, input datapathPkg::word_t expected);
		ctlQ.push_back(ctl);
		opQ.push_back(op);
		dataQ.push_back(data);
		expQ.push_back(hasExp);
		expWordQ.push_back(expected);
	endtask

	task automatic loadFromPort(input datapathPkg::word_t data, input logic [28:0] ctl);
		addRow(mInPortIn, datapathPkg::opAdd, data, 1'b0, '0);
		addRow(mInPortOut | ctl, datapathPkg::opAdd, '0, 1'b0, '0);
	endtask

	task automatic sendOut(input logic [28:0] ctl, input datapathPkg::word_t expected);
		addRow(ctl | mOutPortIn, datapathPkg::opAdd, '0, 1'b1, expected);
	endtask

	task automatic idleRows(input int count, input logic [28:0] ctl);
		for (int i = 0; i < count; i++) begin
			addRow(ctl, datapathPkg::opAdd, '0, 1'b0, '0);
		end
	endtask

	task automatic storeWord(input datapathPkg::word_t addr, input datapathPkg::word_t data);
		loadFromPort(addr, mMarIn);
		loadFromPort(data, mMdrIn);
		addRow(mWrite, datapathPkg::opAdd, '0, 1'b0, '0);
	endtask

	task automatic fetchAndSend(input datapathPkg::word_t addr, input datapathPkg::word_t data);
		loadFromPort(addr, mMarIn);
		addRow(mRead | mMdrIn, datapathPkg::opAdd, '0, 1'b0, '0);
		sendOut(mMdrOut, data);
	endtask

	// Y holds aluA and the input port holds aluB.
	task automatic aluStep(input datapathPkg::aluOp_t op, input datapathPkg::word_t expected);
		addRow(mInPortOut | mZIn, op, '0, 1'b0, '0);
		sendOut(mZLowOut, expected);
	endtask

	task automatic buildTable();
		logic [63:0] product;
		product = 64'(mulA) * 64'(mulB);
		// Registers, memory and the PC to MAR fetch sequence.
		loadFromPort(irFields(4'd2, 4'd3, 4'd0), mIrIn);
		loadFromPort(32'h1234_5678, mGra | mRIn);
		loadFromPort(32'hCAFE_0001, mGrb | mRIn);
		sendOut(mGra | mROut, 32'h1234_5678);
		sendOut(mGrb | mROut, 32'hCAFE_0001);
		storeWord(32'd10, 32'hA5A5_0F0F);
		loadFromPort(32'd10, mPcIn | mMdrIn);
		addRow(mPcOut | mMarIn | mZIn | mIncPc, datapathPkg::opAdd, '0, 1'b0, '0);
		addRow(mZLowOut | mPcIn, datapathPkg::opAdd, '0, 1'b0, '0);
		addRow(mRead | mMdrIn, datapathPkg::opAdd, '0, 1'b0, '0);
		addRow(mMdrOut | mIrIn, datapathPkg::opAdd, '0, 1'b0, '0);
		sendOut(mMdrOut, 32'hA5A5_0F0F);
		sendOut(mCOut, signExtend19(32'hA5A5_0F0F));
		sendOut(mPcOut, 32'd11);
		// ALU operations.
		loadFromPort(aluA, mYIn);
		addRow(mInPortIn, datapathPkg::opAdd, aluB, 1'b0, '0);
		aluStep(datapathPkg::opAdd, aluA + aluB);
		aluStep(datapathPkg::opSub, aluA - aluB);
		aluStep(datapathPkg::opAnd, aluA & aluB);
		aluStep(datapathPkg::opOr, aluA | aluB);
		aluStep(datapathPkg::opShr, aluA >> aluB[4:0]);
		aluStep(datapathPkg::opShl, aluA << aluB[4:0]);
		aluStep(datapathPkg::opNeg, -aluB);
		aluStep(datapathPkg::opNot, ~aluB);
		loadFromPort(mulA, mYIn);
		addRow(mInPortIn, datapathPkg::opAdd, mulB, 1'b0, '0);
		addRow(mInPortOut | mZIn, datapathPkg::opMul, '0, 1'b0, '0);
		addRow(mZHighOut | mHiIn, datapathPkg::opAdd, '0, 1'b0, '0);
		addRow(mZLowOut | mLoIn, datapathPkg::opAdd, '0, 1'b0, '0);
		sendOut(mHiOut, product[63:32]);
		sendOut(mLoOut, product[31:0]);
		sendOut(mZHighOut, product[63:32]);
		// Memory round trip over two addresses.
		storeWord(32'd20, 32'h0BAD_F00D);
		storeWord(32'd277, 32'h7E57_1234);
		fetchAndSend(32'd20, 32'h0BAD_F00D);
		fetchAndSend(32'd277, 32'h7E57_1234);
		// R0 reads as zero only under baOut.
		loadFromPort(irFields(4'd0, 4'd3, 4'd2), mIrIn);
		loadFromPort(32'h5555_AAAA, mGra | mRIn);
		sendOut(mGra | mBaOut, 32'h0);
		sendOut(mGra | mROut, 32'h5555_AAAA);
		sendOut(mGrb | mBaOut, 32'hCAFE_0001);
		sendOut(mGrc | mROut, 32'h1234_5678);
		// Six words with credit withheld leave four in the queue.
		loadFromPort(32'h1111_0001, mYIn);
		loadFromPort(32'h2222_0002, mHiIn);
		loadFromPort(32'h3333_0003, mLoIn);
		loadFromPort(32'h4444_0004, mPcIn);
		loadFromPort(32'h5555_0005, mMdrIn);
		addRow(mInPortIn, datapathPkg::opAdd, 32'h6666_0006, 1'b0, '0);
		idleRows(12, '0);
		sendOut(mYOut | mHold, 32'h1111_0001);
		sendOut(mHiOut | mHold, 32'h2222_0002);
		sendOut(mLoOut | mHold, 32'h3333_0003);
		sendOut(mPcOut | mHold, 32'h4444_0004);
		sendOut(mMdrOut | mHold, 32'h5555_0005);
		sendOut(mInPortOut | mHold, 32'h6666_0006);
		idleRows(4, mHold);
	endtask

	task automatic applyControl(input logic [28:0] ctl, input datapathPkg::aluOp_t op,
		input datapathPkg::word_t data);
		{cOut, inPortOut, mdrOut, pcOut, zLowOut, zHighOut, yOut, loOut, hiOut,
			outPortIn, inPortIn, mdrIn, marIn, irIn, pcIn, zIn, yIn, loIn, hiIn,
			baOut, rOut, rIn, grc, grb, gra, incPc, write, read} = ctl[27:0];
		opcode = op;
		inPortData = data;
	endtask

	// The sink returns a credit for a delivered word on a random later cycle.
	task automatic driveCredit(input logic hold);
		lcgState = nextRandom(lcgState);
		creditReturn = 1'b0;
		if (!hold && pendingCredits > 0 && lcgState[17:16] != 2'b00) begin
			creditReturn = 1'b1;
			pendingCredits--;
		end
		if (outValid) begin
			pendingCredits++;
		end
	endtask

	task automatic runRow(input logic [28:0] ctl, input datapathPkg::aluOp_t op,
		input datapathPkg::word_t data, input bit hasExp, input datapathPkg::word_t expected);
		@(negedge Clock);
		applyControl(ctl, op, data);
		expValid = hasExp;
		expWord = expected;
		driveCredit((ctl & mHold) != '0);
	endtask

	always @(posedge Clock) begin
		cycleCount++;
		if (timeoutLimit > 0 && cycleCount > timeoutLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		int drainCycles;
		Clock = 1'b0;
		rstN = 1'b0;
		applyControl('0, datapathPkg::opAdd, '0);
		creditReturn = 1'b0;
		expValid = 1'b0;
		expWord = '0;
		endOfTest = 1'b0;
		buildTable();
		timeoutLimit = ctlQ.size() + 4 * `OUT_QUEUE_DEPTH * 20;
		repeat (3) @(negedge Clock);
		rstN = 1'b1;
		for (int i = 0; i < ctlQ.size(); i++) begin
			runRow(ctlQ[i], opQ[i], dataQ[i], expQ[i], expWordQ[i]);
		end
		drainCycles = 0;
		while (pendingCount != 0 && drainCycles < 16 * `OUT_QUEUE_DEPTH) begin
			runRow('0, datapathPkg::opAdd, '0, 1'b0, '0);
			drainCycles++;
		end
		@(negedge Clock);
		expValid = 1'b0;
		endOfTest = 1'b1;
		while (!endReported) begin
			@(negedge Clock);
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- memoryInterface.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module memoryInterface (
	input  logic                Clock,
	input  logic                rstN,
	input  logic                marIn,
	input  logic                mdrIn,
	input  logic                read,
	input  logic                write,
	input  datapathPkg::word_t  bus,
	output datapathPkg::word_t  mdrValue
);

	localparam int addrWidth = $clog2(`MEM_DEPTH);

	datapathPkg::word_t   memArray [`MEM_DEPTH];
	logic [addrWidth-1:0] marReg;
	datapathPkg::word_t   mdrReg;

	// Only the low address bits are kept.
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			marReg <= '0;
		end else if (marIn) begin
			marReg <= bus[addrWidth-1:0];
		end
	end

	// MDR loads memory data on a read, the bus otherwise.
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			mdrReg <= '0;
		end else if (mdrIn) begin
			if (read) begin
				mdrReg <= memArray[marReg];
			end else begin
				mdrReg <= bus;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (write) begin
			memArray[marReg] <= mdrReg;
		end
	end

	assign mdrValue = mdrReg;

	noReadWrite: assert property (@(posedge Clock) disable iff (!rstN)
		!(read && write));

endmodule

`default_nettype wire

//--- outPortLink.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module outPortLink (
	input  logic                Clock,
	input  logic                rstN,
	input  logic                outPortIn,
	input  logic                inPortIn,
	input  logic                creditReturn,
	input  datapathPkg::word_t  bus,
	input  datapathPkg::word_t  inPortData,
	output datapathPkg::word_t  inPortValue,
	output datapathPkg::word_t  outData,
	output logic                outValid,
	output logic                outFull
);

	localparam int ptrWidth = $clog2(`OUT_QUEUE_DEPTH);
	localparam int countWidth = $clog2(`OUT_QUEUE_DEPTH + 1);
	localparam int creditWidth = $clog2(`SINK_CREDITS + 1);

	datapathPkg::word_t     queue [`OUT_QUEUE_DEPTH];
	datapathPkg::word_t     inPortReg;
	logic [ptrWidth-1:0]    headPtr;
	logic [ptrWidth-1:0]    tailPtr;
	logic [countWidth-1:0]  count;
	logic [creditWidth-1:0] credits;
	logic                   push;
	logic                   pop;

	assign outFull = (count == countWidth'(`OUT_QUEUE_DEPTH));
	assign outValid = (count != '0) && (credits != '0);
	assign outData = queue[headPtr];
	assign pop = outValid;
	assign push = outPortIn && !outFull;
	assign inPortValue = inPortReg;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			inPortReg <= '0;
		end else if (inPortIn) begin
			inPortReg <= inPortData;
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `OUT_QUEUE_DEPTH; i++) begin
				queue[i] <= '0;
			end
			headPtr <= '0;
			tailPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				queue[tailPtr] <= bus;
				tailPtr <= (tailPtr == ptrWidth'(`OUT_QUEUE_DEPTH - 1)) ? '0 : tailPtr + 1'b1;
			end
			if (pop) begin
				headPtr <= (headPtr == ptrWidth'(`OUT_QUEUE_DEPTH - 1)) ? '0 : headPtr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// One credit leaves with each word, one comes back per return pulse.
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			credits <= creditWidth'(`SINK_CREDITS);
		end else if (pop && !creditReturn) begin
			credits <= credits - 1'b1;
		end else if (creditReturn && !pop) begin
			credits <= credits + 1'b1;
		end
	end

	creditBound: assert property (@(posedge Clock) disable iff (!rstN)
		credits <= creditWidth'(`SINK_CREDITS));

	noPushWhenFull: assert property (@(posedge Clock) disable iff (!rstN)
		!(outPortIn && outFull));

endmodule

`default_nettype wire

//--- project.f
+incdir+.
datapathPkg.sv
busDriver.sv
registerFile.sv
aluUnit.sv
memoryInterface.sv
outPortLink.sv
datapath.sv
datapathChecker.sv
datapath_tb.sv

//--- registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module registerFile (
	input  logic                Clock,
	input  logic                rstN,
	input  logic                gra,
	input  logic                grb,
	input  logic                grc,
	input  logic                rIn,
	input  logic                rOut,
	input  logic                baOut,
	input  logic                pcIn,
	input  logic                irIn,
	input  datapathPkg::word_t  bus,
	output datapathPkg::word_t  regValue,
	output datapathPkg::word_t  pcValue,
	output datapathPkg::word_t  irValue
);

	localparam int selWidth = $clog2(`REG_COUNT);

	datapathPkg::word_t  regs [`REG_COUNT];
	datapathPkg::word_t  pcReg;
	datapathPkg::word_t  irReg;
	logic [selWidth-1:0] regSel;

	// IR fields: ra at 26:23, rb at 22:19, rc at 18:15.
	always_comb begin
		regSel = '0;
		if (gra) begin
			regSel = irReg[26 -: selWidth];
		end else if (grb) begin
			regSel = irReg[22 -: selWidth];
		end else if (grc) begin
			regSel = irReg[18 -: selWidth];
		end
	end

	// Base-address reads of R0 give zero.
	assign regValue = (baOut && regSel == '0) ? '0 : regs[regSel];
	assign pcValue = pcReg;
	assign irValue = irReg;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
			pcReg <= '0;
			irReg <= '0;
		end else begin
			if (rIn) begin
				regs[regSel] <= bus;
			end
			if (pcIn) begin
				pcReg <= bus;
			end
			if (irIn) begin
				irReg <= bus;
			end
		end
	end

	selectOneHot: assert property (@(posedge Clock) disable iff (!rstN)
		(rIn || rOut) |-> $onehot0({gra, grb, grc}));

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module datapath_tb \
	-f project.f -o datapathSim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/datapathSim > sim.log 2>&1 \
	|| { cat sim.log; echo "Simulation stopped abnormally"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0
